/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_soc_top -f soc_periph.f -o vtb
	-./obj_dir/vtb > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Finished with errors" $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/soc_top_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SoC top properties
// Bus acknowledge timing, select exclusivity and quiet
// interrupt lines after reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module soc_top_properties (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  soc_bus_pkg::type_lsu2dbus_s  lsu2dbus_i,
    input  soc_bus_pkg::type_dbus2lsu_s  dbus2lsu_i,
    input  logic                         dmem_sel_i,
    input  logic                         clint_sel_i,
    input  logic                         plic_sel_i,
    input  soc_irq_pkg::type_irq2core_s  irq2core_i
);

    // Set by the first write request after reset
    logic written_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            written_q <= 1'b0;
        end else if (lsu2dbus_i.req && lsu2dbus_i.we) begin
            written_q <= 1'b1;
        end
    end

    ack_after_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu2dbus_i.req |=> dbus2lsu_i.ack)
        else $error("ack missing one cycle after a request");

    no_ack_without_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        !lsu2dbus_i.req |=> !dbus2lsu_i.ack)
        else $error("ack raised without a request");

    sel_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0({dmem_sel_i, clint_sel_i, plic_sel_i}))
        else $error("more than one slave select high");

    irq_quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n_i)
        !written_q |-> (irq2core_i == '0))
        else $error("interrupt line high before any write");

endmodule : soc_top_properties

bind soc_top soc_top_properties i_soc_top_properties (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .lsu2dbus_i  (lsu2dbus_i),
    .dbus2lsu_i  (dbus2lsu_o),
    .dmem_sel_i  (dmem_sel),
    .clint_sel_i (clint_sel),
    .plic_sel_i  (plic_sel),
    .irq2core_i  (irq2core_o)
);

/* dv/tb_soc_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SoC top testbench
// Acts as the load/store unit and interrupt sources, checks
// reads against a shadow model of memory, CLINT and PLIC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_soc_top;

    import soc_bus_pkg::*;
    import soc_irq_pkg::*;

    logic                         clk;
    logic                         arst_n_i;
    type_lsu2dbus_s               lsu2dbus;
    type_dbus2lsu_s               dbus2lsu;
    logic [PLIC_SOURCE_COUNT-1:0] irq_src;
    type_irq2core_s               irq2core;

    int errors;
    int checks;

    // Shadow model
    logic [31:0]                mem_model [DMEM_WORDS];
    logic                       msip_m;
    logic [63:0]                mtimecmp_m;
    logic [PLIC_PRIO_W-1:0]     prio_m [1:PLIC_SOURCE_COUNT];
    logic [PLIC_SOURCE_COUNT:1] pending_m;
    logic [PLIC_SOURCE_COUNT:1] enable_m;
    logic [PLIC_SOURCE_COUNT:1] in_service_m;
    logic [PLIC_SOURCE_COUNT:1] levels_m;
    logic [PLIC_PRIO_W-1:0]     threshold_m;

    soc_top i_soc_top (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .lsu2dbus_i (lsu2dbus),
        .dbus2lsu_o (dbus2lsu),
        .irq_src_i  (irq_src),
        .irq2core_o (irq2core)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] clint_addr(input logic [CLINT_OFF_W-1:0] off);
        return CLINT_BASE + 32'(off);
    endfunction

    function automatic logic [31:0] plic_addr(input logic [PLIC_OFF_W-1:0] off);
        return PLIC_BASE + 32'(off);
    endfunction

    function automatic logic in_region(input logic [31:0] addr, input logic [31:0] base,
                                       input logic [31:0] size);
        return (addr >= base) && (addr < base + size);
    endfunction

    // Highest priority above threshold, equal priority goes to the lower ID
    function automatic int claim_winner();
        int                     winner;
        logic [PLIC_PRIO_W-1:0] best;
        winner = 0;
        best   = '0;
        for (int n = PLIC_SOURCE_COUNT; n >= 1; n--) begin
            if (pending_m[n] && enable_m[n] && (prio_m[n] > threshold_m)
                    && ((winner == 0) || (prio_m[n] >= best))) begin
                winner = n;
                best   = prio_m[n];
            end
        end
        return winner;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] off;
        logic [31:0] result;
        result = 32'd0;
        if (in_region(addr, DMEM_BASE, DMEM_SIZE)) begin
            result = mem_model[addr[DMEM_AW+1:2]];
        end else if (in_region(addr, CLINT_BASE, CLINT_SIZE)) begin
            off = addr - CLINT_BASE;
            // mtime is free running and checked by range elsewhere
            case (off)
                32'(CLINT_MSIP_OFF):        result = {31'd0, msip_m};
                32'(CLINT_MTIMECMP_LO_OFF): result = mtimecmp_m[31:0];
                32'(CLINT_MTIMECMP_HI_OFF): result = mtimecmp_m[63:32];
                default:                    result = 32'd0;
            endcase
        end else if (in_region(addr, PLIC_BASE, PLIC_SIZE)) begin
            off = addr - PLIC_BASE;
            for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
                if (off == 32'(4 * n)) begin
                    result = 32'(prio_m[n]);
                end
            end
            case (off)
                32'(PLIC_PENDING_OFF):   result = 32'({pending_m, 1'b0});
                32'(PLIC_ENABLE_OFF):    result = 32'({enable_m, 1'b0});
                32'(PLIC_THRESHOLD_OFF): result = 32'(threshold_m);
                32'(PLIC_CLAIM_OFF):     result = 32'(claim_winner());
                default: ;
            endcase
        end
        return result;
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] off;
        if (in_region(addr, DMEM_BASE, DMEM_SIZE)) begin
            mem_model[addr[DMEM_AW+1:2]] = data;
        end else if (in_region(addr, CLINT_BASE, CLINT_SIZE)) begin
            off = addr - CLINT_BASE;
            if (off == 32'(CLINT_MSIP_OFF)) msip_m = data[0];
            if (off == 32'(CLINT_MTIMECMP_LO_OFF)) mtimecmp_m[31:0] = data;
            if (off == 32'(CLINT_MTIMECMP_HI_OFF)) mtimecmp_m[63:32] = data;
        end else if (in_region(addr, PLIC_BASE, PLIC_SIZE)) begin
            off = addr - PLIC_BASE;
            for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
                if (off == 32'(4 * n)) prio_m[n] = data[PLIC_PRIO_W-1:0];
                // Complete
                if ((off == 32'(PLIC_CLAIM_OFF)) && (data == 32'(n))) in_service_m[n] = 1'b0;
            end
            if (off == 32'(PLIC_ENABLE_OFF)) enable_m = data[PLIC_SOURCE_COUNT:1];
            if (off == 32'(PLIC_THRESHOLD_OFF)) threshold_m = data[PLIC_PRIO_W-1:0];
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // One request, then wait for its acknowledge
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic we, output logic [31:0] rdata);
        int   cycles;
        logic acked;
        lsu2dbus.addr  = addr;
        lsu2dbus.wdata = wdata;
        lsu2dbus.we    = we;
        lsu2dbus.req   = 1'b1;
        acked  = 1'b0;
        cycles = 0;
        while (!acked && (cycles < 10)) begin
            @(posedge clk);
            #1;
            cycles++;
            acked = dbus2lsu.ack;
        end
        lsu2dbus.req = 1'b0;
        rdata        = dbus2lsu.rdata;
        if (!acked) begin
            errors++;
            $display("request to address %h was not acknowledged within 10 cycles", addr);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(addr, data, 1'b1, unused);
        model_write(addr, data);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_access(addr, 32'd0, 1'b0, data);
    endtask

    task automatic read_check(input string name, input logic [31:0] addr);
        logic [31:0] expected;
        logic [31:0] actual;
        int          id;
        expected = ref_read(addr);
        bus_read(addr, actual);
        check_value(name, expected, actual);
        // A successful claim puts the winner in service
        if ((addr == plic_addr(PLIC_CLAIM_OFF)) && (expected != 32'd0)) begin
            id               = int'(expected);
            pending_m[id]    = 1'b0;
            in_service_m[id] = 1'b1;
        end
    endtask

    // Let the gateway latch raised sources
    task automatic settle_sources();
        idle(3);
        pending_m = pending_m | (levels_m & ~in_service_m);
    endtask

    task automatic check_ext_irq(input string name);
        check_value(name, 32'(claim_winner() != 0), 32'(irq2core.ext_irq));
    endtask

    initial begin
        logic [31:0] lo;
        logic [31:0] hi;
        logic [63:0] mtime_v;
        logic [63:0] cmp;
        int          idx;
        int          waited;
        logic [31:0] addr_q [$];

        void'($urandom(32'hf4783946));
        errors       = 0;
        checks       = 0;
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        lsu2dbus     = '0;
        irq_src      = '0;
        msip_m       = 1'b0;
        mtimecmp_m   = '1;
        pending_m    = '0;
        enable_m     = '0;
        in_service_m = '0;
        levels_m     = '0;
        threshold_m  = '0;
        for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
            prio_m[n] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        idle(1);

        // Reset values
        check_value("reset irq lines", 32'd0, 32'(irq2core));
        read_check("reset msip", clint_addr(CLINT_MSIP_OFF));
        read_check("reset mtimecmp lo", clint_addr(CLINT_MTIMECMP_LO_OFF));
        read_check("reset mtimecmp hi", clint_addr(CLINT_MTIMECMP_HI_OFF));
        for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
            read_check("reset plic priority", plic_addr(PLIC_OFF_W'(4 * n)));
        end
        read_check("reset plic pending", plic_addr(PLIC_PENDING_OFF));
        read_check("reset plic enable", plic_addr(PLIC_ENABLE_OFF));
        read_check("reset plic threshold", plic_addr(PLIC_THRESHOLD_OFF));
        read_check("reset plic claim", plic_addr(PLIC_CLAIM_OFF));

        // Data memory, back-to-back writes then readback
        for (int i = 0; i < 16; i++) begin
            idx = int'($urandom % DMEM_WORDS);
            addr_q.push_back(DMEM_BASE + 32'(idx * 4));
            bus_write(addr_q[i], $urandom);
        end
        foreach (addr_q[i]) begin
            read_check("dmem readback", addr_q[i]);
        end

        // Unmapped space
        bus_write(DMEM_BASE, 32'ha5a5_5a5a);
        read_check("unmapped low read", 32'h1000_0000);
        read_check("unmapped past dmem read", DMEM_BASE + DMEM_SIZE);
        read_check("unmapped top read", 32'hffff_fffc);
        bus_write(DMEM_BASE + DMEM_SIZE, $urandom);
        bus_write(CLINT_BASE + CLINT_SIZE, 32'd1);
        read_check("dmem after unmapped write", DMEM_BASE);
        read_check("msip after unmapped write", clint_addr(CLINT_MSIP_OFF));

        // Software interrupt
        bus_write(clint_addr(CLINT_MSIP_OFF), 32'd1);
        check_value("soft irq set", 32'd1, 32'(irq2core.soft_irq));
        read_check("msip set", clint_addr(CLINT_MSIP_OFF));
        bus_write(clint_addr(CLINT_MSIP_OFF), 32'd0);
        check_value("soft irq clear", 32'd0, 32'(irq2core.soft_irq));

        // Timer, low word of mtimecmp first so it never matches early
        bus_read(clint_addr(CLINT_MTIME_LO_OFF), lo);
        bus_read(clint_addr(CLINT_MTIME_HI_OFF), hi);
        mtime_v = {hi, lo};
        cmp     = mtime_v + 64'd40;
        bus_write(clint_addr(CLINT_MTIMECMP_LO_OFF), cmp[31:0]);
        bus_write(clint_addr(CLINT_MTIMECMP_HI_OFF), cmp[63:32]);
        check_value("timer irq low", 32'd0, 32'(irq2core.timer_irq));
        read_check("mtimecmp lo", clint_addr(CLINT_MTIMECMP_LO_OFF));
        read_check("mtimecmp hi", clint_addr(CLINT_MTIMECMP_HI_OFF));
        waited = 0;
        while (!irq2core.timer_irq && (waited < 200)) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!irq2core.timer_irq) begin
            errors++;
            $display("timer interrupt did not rise within 200 cycles");
        end
        bus_read(clint_addr(CLINT_MTIME_LO_OFF), lo);
        bus_read(clint_addr(CLINT_MTIME_HI_OFF), hi);
        mtime_v = {hi, lo};
        check_value("mtime reached mtimecmp", 32'd1, 32'(mtime_v >= cmp));

        // PLIC with both sources raised
        irq_src  = '1;
        levels_m = irq_src;
        settle_sources();
        for (int round = 0; round < 4; round++) begin
            for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
                bus_write(plic_addr(PLIC_OFF_W'(4 * n)), $urandom % 8);
            end
            bus_write(plic_addr(PLIC_ENABLE_OFF), ($urandom % 4) << 1);
            bus_write(plic_addr(PLIC_THRESHOLD_OFF), $urandom % 4);
            idle(2);
            check_ext_irq("ext irq after config");
            read_check("plic pending", plic_addr(PLIC_PENDING_OFF));
            // One extra claim to see zero once nothing qualifies
            for (int c = 0; c <= PLIC_SOURCE_COUNT; c++) begin
                read_check("plic claim", plic_addr(PLIC_CLAIM_OFF));
                read_check("plic pending after claim", plic_addr(PLIC_PENDING_OFF));
                idle(2);
                check_ext_irq("ext irq after claim");
            end
            for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
                if (in_service_m[n]) begin
                    bus_write(plic_addr(PLIC_CLAIM_OFF), 32'(n));
                end
            end
            settle_sources();
            check_ext_irq("ext irq after complete");
            read_check("plic pending after complete", plic_addr(PLIC_PENDING_OFF));
        end
        bus_write(plic_addr(PLIC_THRESHOLD_OFF), 32'd7);
        read_check("plic claim above threshold", plic_addr(PLIC_CLAIM_OFF));
        idle(2);
        check_ext_irq("ext irq above threshold");

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_soc_top

/* rtl/clint.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core-local interruptor
// Machine timer with compare and software interrupt bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module clint (
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  soc_bus_pkg::type_dbus2peri_s dbus2peri_i,
    input  logic                         clint_sel_i,
    output soc_bus_pkg::type_peri2dbus_s clint2dbus_o,

    output logic                         timer_irq_o,
    output logic                         soft_irq_o
);

    import soc_irq_pkg::*;

    logic [63:0]            mtime_q;
    logic [63:0]            mtimecmp_q;
    logic                   msip_q;
    logic                   timer_irq_q;
    logic [CLINT_OFF_W-1:0] reg_off;
    logic                   wr_en;
    logic [31:0]            rd_word;
    logic [31:0]            rdata_q;

    assign reg_off = dbus2peri_i.addr[CLINT_OFF_W-1:0];
    assign wr_en   = clint_sel_i & dbus2peri_i.we;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            msip_q      <= 1'b0;
            timer_irq_q <= 1'b0;
        end else begin
            mtime_q     <= mtime_q + 64'd1;
            timer_irq_q <= (mtime_q >= mtimecmp_q);
            if (wr_en) begin
                case (reg_off)
                    CLINT_MSIP_OFF:        msip_q <= dbus2peri_i.wdata[0];
                    CLINT_MTIMECMP_LO_OFF: mtimecmp_q[31:0] <= dbus2peri_i.wdata;
                    CLINT_MTIMECMP_HI_OFF: mtimecmp_q[63:32] <= dbus2peri_i.wdata;
                    // A write to mtime replaces this cycle's increment
                    CLINT_MTIME_LO_OFF:    mtime_q <= {mtime_q[63:32], dbus2peri_i.wdata};
                    CLINT_MTIME_HI_OFF:    mtime_q <= {dbus2peri_i.wdata, mtime_q[31:0]};
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_off)
            CLINT_MSIP_OFF:        rd_word = {31'd0, msip_q};
            CLINT_MTIMECMP_LO_OFF: rd_word = mtimecmp_q[31:0];
            CLINT_MTIMECMP_HI_OFF: rd_word = mtimecmp_q[63:32];
            CLINT_MTIME_LO_OFF:    rd_word = mtime_q[31:0];
            CLINT_MTIME_HI_OFF:    rd_word = mtime_q[63:32];
            default:               rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (clint_sel_i) begin
            rdata_q <= rd_word;
        end
    end

    assign clint2dbus_o.rdata = rdata_q;
    assign timer_irq_o        = timer_irq_q;
    assign soft_irq_o         = msip_q;

endmodule : clint

/* rtl/dbus_interconnect.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data bus interconnect
// Decodes LSU requests into slave selects and returns the
// acknowledged read word one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dbus_interconnect (
    input  logic                         clk,
    input  logic                         arst_n_i,

    // Load/store unit side
    input  soc_bus_pkg::type_lsu2dbus_s  lsu2dbus_i,
    output soc_bus_pkg::type_dbus2lsu_s  dbus2lsu_o,

    // Slave side
    output soc_bus_pkg::type_dbus2peri_s dbus2peri_o,
    output logic                         dmem_sel_o,
    output logic                         clint_sel_o,
    output logic                         plic_sel_o,
    input  soc_bus_pkg::type_peri2dbus_s dmem2dbus_i,
    input  soc_bus_pkg::type_peri2dbus_s clint2dbus_i,
    input  soc_bus_pkg::type_peri2dbus_s plic2dbus_i
);

    import soc_bus_pkg::*;

    logic        dmem_hit;
    logic        clint_hit;
    logic        plic_hit;
    // One-hot region of the request in flight, {plic, clint, dmem}
    logic [2:0]  region_q;
    logic        ack_q;
    logic [31:0] rdata_mux;

    // Unsigned wrap makes one compare cover both region bounds
    assign dmem_hit  = (lsu2dbus_i.addr - DMEM_BASE) < DMEM_SIZE;
    assign clint_hit = (lsu2dbus_i.addr - CLINT_BASE) < CLINT_SIZE;
    assign plic_hit  = (lsu2dbus_i.addr - PLIC_BASE) < PLIC_SIZE;

    assign dmem_sel_o  = lsu2dbus_i.req & dmem_hit;
    assign clint_sel_o = lsu2dbus_i.req & clint_hit;
    assign plic_sel_o  = lsu2dbus_i.req & plic_hit;

    // Same-cycle broadcast to all slaves
    assign dbus2peri_o.addr  = lsu2dbus_i.addr;
    assign dbus2peri_o.wdata = lsu2dbus_i.wdata;
    assign dbus2peri_o.we    = lsu2dbus_i.we;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q    <= 1'b0;
            region_q <= '0;
        end else begin
            // Unmapped requests still get acknowledged
            ack_q    <= lsu2dbus_i.req;
            region_q <= {plic_sel_o, clint_sel_o, dmem_sel_o};
        end
    end

    // Unmapped reads fall through as zero
    assign rdata_mux = ({32{region_q[0]}} & dmem2dbus_i.rdata)
                     | ({32{region_q[1]}} & clint2dbus_i.rdata)
                     | ({32{region_q[2]}} & plic2dbus_i.rdata);

    assign dbus2lsu_o.rdata = rdata_mux;
    assign dbus2lsu_o.ack   = ack_q;

endmodule : dbus_interconnect

/* rtl/dmem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory
// Single-port synchronous word memory on the data bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dmem (
    input  logic                         clk,

    input  soc_bus_pkg::type_dbus2peri_s dbus2peri_i,
    input  logic                         dmem_sel_i,
    output soc_bus_pkg::type_peri2dbus_s dmem2dbus_o
);

    import soc_bus_pkg::*;

    logic [31:0]        mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [31:0]        rdata_q;

    // Word index, byte offset bits ignored
    assign word_idx = dbus2peri_i.addr[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (dmem_sel_i) begin
            if (dbus2peri_i.we) begin
                mem[word_idx] <= dbus2peri_i.wdata;
            end
            // Read-before-write on a write cycle
            rdata_q <= mem[word_idx];
        end
    end

    assign dmem2dbus_o.rdata = rdata_q;

endmodule : dmem

/* rtl/plic.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Platform-level interrupt controller
// Level sources, priority arbitration, claim and complete
// for a single target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module plic (
    input  logic                                     clk,
    input  logic                                     arst_n_i,

    input  soc_bus_pkg::type_dbus2peri_s             dbus2peri_i,
    input  logic                                     plic_sel_i,
    output soc_bus_pkg::type_peri2dbus_s             plic2dbus_o,

    input  logic [soc_irq_pkg::PLIC_SOURCE_COUNT-1:0] irq_src_i,
    output logic                                     irq_target_o
);

    import soc_irq_pkg::*;

    logic [PLIC_OFF_W-1:0]        reg_off;
    logic                         wr_en;
    logic                         claim_rd;
    logic [PLIC_PRIO_W-1:0]       prio_q [1:PLIC_SOURCE_COUNT];
    logic [PLIC_SOURCE_COUNT:1]   pending_q;
    logic [PLIC_SOURCE_COUNT:1]   enable_q;
    logic [PLIC_SOURCE_COUNT:1]   in_service_q;
    logic [PLIC_PRIO_W-1:0]       threshold_q;
    logic [PLIC_ID_W-1:0]         best_id;
    logic [PLIC_PRIO_W-1:0]       best_prio;
    logic                         ext_irq_q;
    logic [31:0]                  rd_word;
    logic [31:0]                  rdata_q;

    assign reg_off  = dbus2peri_i.addr[PLIC_OFF_W-1:0];
    assign wr_en    = plic_sel_i & dbus2peri_i.we;
    assign claim_rd = plic_sel_i & ~dbus2peri_i.we & (reg_off == PLIC_CLAIM_OFF);

    // Strict compare keeps the lower ID on a tie, threshold is the floor
    always_comb begin
        best_id   = '0;
        best_prio = threshold_q;
        for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
            if (pending_q[n] && enable_q[n] && (prio_q[n] > best_prio)) begin
                best_id   = PLIC_ID_W'(n);
                best_prio = prio_q[n];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
                prio_q[n] <= '0;
            end
            pending_q    <= '0;
            enable_q     <= '0;
            in_service_q <= '0;
            threshold_q  <= '0;
            ext_irq_q    <= 1'b0;
        end else begin
            ext_irq_q <= (best_id != '0);
            // Gateway, sources in service are masked
            for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
                if (irq_src_i[n-1] && !in_service_q[n]) begin
                    pending_q[n] <= 1'b1;
                end
            end
            if (claim_rd && (best_id != '0)) begin
                pending_q[best_id]    <= 1'b0;
                in_service_q[best_id] <= 1'b1;
            end
            if (wr_en) begin
                for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
                    if (reg_off == PLIC_PRIORITY_OFF + PLIC_OFF_W'(4 * n)) begin
                        prio_q[n] <= dbus2peri_i.wdata[PLIC_PRIO_W-1:0];
                    end
                    // Complete
                    if ((reg_off == PLIC_CLAIM_OFF) && (dbus2peri_i.wdata == 32'(n))) begin
                        in_service_q[n] <= 1'b0;
                    end
                end
                case (reg_off)
                    PLIC_ENABLE_OFF:    enable_q <= dbus2peri_i.wdata[PLIC_SOURCE_COUNT:1];
                    PLIC_THRESHOLD_OFF: threshold_q <= dbus2peri_i.wdata[PLIC_PRIO_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Pending and enable words are bit n for source n
    always_comb begin
        rd_word = '0;
        for (int n = 1; n <= PLIC_SOURCE_COUNT; n++) begin
            if (reg_off == PLIC_PRIORITY_OFF + PLIC_OFF_W'(4 * n)) begin
                rd_word = 32'(prio_q[n]);
            end
        end
        case (reg_off)
            PLIC_PENDING_OFF:   rd_word = 32'({pending_q, 1'b0});
            PLIC_ENABLE_OFF:    rd_word = 32'({enable_q, 1'b0});
            PLIC_THRESHOLD_OFF: rd_word = 32'(threshold_q);
            PLIC_CLAIM_OFF:     rd_word = 32'(best_id);
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (plic_sel_i) begin
            rdata_q <= rd_word;
        end
    end

    assign plic2dbus_o.rdata = rdata_q;
    assign irq_target_o      = ext_irq_q;

endmodule : plic

/* rtl/soc_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data bus definitions
// Request and response structs, peripheral address map and
// data memory geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package soc_bus_pkg;

    // Address map
    localparam logic [31:0] DMEM_BASE  = 32'h8000_0000;
    localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [31:0] PLIC_BASE  = 32'h0C00_0000;

    // Data memory depth in 32-bit words, power of two
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // Region widths in bytes
    localparam logic [31:0] DMEM_SIZE  = 32'(DMEM_WORDS * 4);
    localparam logic [31:0] CLINT_SIZE = 32'h0001_0000;
    localparam logic [31:0] PLIC_SIZE  = 32'h0040_0000;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        logic        req;
    } type_lsu2dbus_s;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ack;
    } type_dbus2lsu_s;

    // Broadcast to every slave
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } type_dbus2peri_s;

    typedef struct packed {
        logic [31:0] rdata;
    } type_peri2dbus_s;

endpackage : soc_bus_pkg

/* rtl/soc_irq_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt definitions
// Core interrupt lines, CLINT and PLIC register offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package soc_irq_pkg;

    typedef struct packed {
        logic ext_irq;
        logic timer_irq;
        logic soft_irq;
    } type_irq2core_s;

    // PLIC geometry, IDs run from 1 to PLIC_SOURCE_COUNT
    localparam int PLIC_SOURCE_COUNT = 2;
    localparam int PLIC_PRIO_W       = 3;
    localparam int PLIC_ID_W         = $clog2(PLIC_SOURCE_COUNT + 1);

    // PLIC offsets within its 4 MiB window
    localparam int                    PLIC_OFF_W         = 22;
    localparam logic [PLIC_OFF_W-1:0] PLIC_PRIORITY_OFF  = 22'h00_0000;
    localparam logic [PLIC_OFF_W-1:0] PLIC_PENDING_OFF   = 22'h00_1000;
    localparam logic [PLIC_OFF_W-1:0] PLIC_ENABLE_OFF    = 22'h00_2000;
    localparam logic [PLIC_OFF_W-1:0] PLIC_THRESHOLD_OFF = 22'h20_0000;
    localparam logic [PLIC_OFF_W-1:0] PLIC_CLAIM_OFF     = 22'h20_0004;

    // CLINT offsets within its 64 KiB window
    localparam int                     CLINT_OFF_W          = 16;
    localparam logic [CLINT_OFF_W-1:0] CLINT_MSIP_OFF       = 16'h0000;
    localparam logic [CLINT_OFF_W-1:0] CLINT_MTIMECMP_LO_OFF = 16'h4000;
    localparam logic [CLINT_OFF_W-1:0] CLINT_MTIMECMP_HI_OFF = 16'h4004;
    localparam logic [CLINT_OFF_W-1:0] CLINT_MTIME_LO_OFF   = 16'hBFF8;
    localparam logic [CLINT_OFF_W-1:0] CLINT_MTIME_HI_OFF   = 16'hBFFC;

endpackage : soc_irq_pkg

/* rtl/soc_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SoC peripheral top
// Data bus interconnect with data memory, CLINT and PLIC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module soc_top (
    input  logic                                     clk,
    input  logic                                     arst_n_i,

    // Load/store unit port
    input  soc_bus_pkg::type_lsu2dbus_s              lsu2dbus_i,
    output soc_bus_pkg::type_dbus2lsu_s              dbus2lsu_o,

    // External interrupt sources and lines to the core
    input  logic [soc_irq_pkg::PLIC_SOURCE_COUNT-1:0] irq_src_i,
    output soc_irq_pkg::type_irq2core_s              irq2core_o
);

    import soc_bus_pkg::*;
    import soc_irq_pkg::*;

    type_dbus2peri_s dbus2peri;
    type_peri2dbus_s dmem2dbus;
    type_peri2dbus_s clint2dbus;
    type_peri2dbus_s plic2dbus;

    logic            dmem_sel;
    logic            clint_sel;
    logic            plic_sel;

    logic            irq_timer;
    logic            irq_soft;
    logic            irq_ext;

    dbus_interconnect i_dbus_interconnect (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .lsu2dbus_i   (lsu2dbus_i),
        .dbus2lsu_o   (dbus2lsu_o),
        .dbus2peri_o  (dbus2peri),
        .dmem_sel_o   (dmem_sel),
        .clint_sel_o  (clint_sel),
        .plic_sel_o   (plic_sel),
        .dmem2dbus_i  (dmem2dbus),
        .clint2dbus_i (clint2dbus),
        .plic2dbus_i  (plic2dbus)
    );

    dmem i_dmem (
        .clk         (clk),
        .dbus2peri_i (dbus2peri),
        .dmem_sel_i  (dmem_sel),
        .dmem2dbus_o (dmem2dbus)
    );

    clint i_clint (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .dbus2peri_i  (dbus2peri),
        .clint_sel_i  (clint_sel),
        .clint2dbus_o (clint2dbus),
        .timer_irq_o  (irq_timer),
        .soft_irq_o   (irq_soft)
    );

    plic i_plic (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .dbus2peri_i  (dbus2peri),
        .plic_sel_i   (plic_sel),
        .plic2dbus_o  (plic2dbus),
        .irq_src_i    (irq_src_i),
        .irq_target_o (irq_ext)
    );

    assign irq2core_o = type_irq2core_s'{
        ext_irq:   irq_ext,
        timer_irq: irq_timer,
        soft_irq:  irq_soft
    };

endmodule : soc_top

/* soc_periph.f */
rtl/soc_bus_pkg.sv
rtl/soc_irq_pkg.sv
rtl/dbus_interconnect.sv
rtl/dmem.sv
rtl/clint.sv
rtl/plic.sv
rtl/soc_top.sv
dv/soc_top_properties.sv
dv/tb_soc_top.sv
